/* verilog.f */
verilog/bpi_cmd_pkg.sv
verilog/bpi_flash_pkg.sv
verilog/bpi_cmd_fifo.sv
verilog/bpi_cmd_parser.sv
verilog/bpi_cycle_gen.sv
verilog/bpi_rbk_out.sv
verilog/bpi_ctrl_top.sv
bench/bpi_ctrl_sva.sv
bench/bpi_ctrl_tb.sv

/* bench/bpi_ctrl_tb.sv */
`timescale 1ns/100ps

module bpi_ctrl_tb;

	import bpi_cmd_pkg::*;
	import bpi_flash_pkg::*;

	logic        CLK = 1'b0;
	logic        local_rst = 1'b1;
	logic        cmd_we = 1'b0;
	word_t       cmd_data = '0;
	logic        rbk_credit = 1'b0;
	logic        bpi_busy = 1'b0;
	logic        bpi_load_data = 1'b0;
	word_t       bpi_data_from = '0;
	logic        cmd_credit;
	logic        rbk_valid;
	word_t       rbk_data;
	logic        bpi_execute;
	bus_op_t     bpi_op;
	flash_addr_t bpi_addr;
	word_t       bpi_data_to;
	word_t       bpi_status;
	logic        bpi_active;

	// Expected bus cycles and readback words
	bus_op_t     exp_op[$];
	flash_addr_t exp_addr[$];
	word_t       exp_dat[$];
	word_t       exp_rbk[$];

	int mismatch_cnt = 0;
	int other_cnt = 0;
	int wr_cnt = 0;		// Words written under credit
	int cr_rx = 0;		// cmd_credit pulses seen
	int rbk_rx = 0;
	int ret_cnt = 0;	// rbk_credit pulses returned
	logic withhold = 1'b0;
	flash_addr_t cur_addr = '0;	// Parser address pointer as the host sees it

	// Flash model state
	bus_op_t     pend_op;
	flash_addr_t pend_addr;
	word_t       pend_data;
	logic        exec_tog = 1'b0;
	logic        seen_tog = 1'b0;
	int          busy_cnt = 0;
	logic        m_read = 1'b0;
	logic        st_mode = 1'b0;
	logic        prog_next = 1'b0;
	int          polls_left = 0;
	int          poll_plan = 0;
	logic [6:0]  err_pat = '0;
	bus_op_t     e_op;

	bpi_ctrl_top u_bpi_ctrl_top (
		.CLK(CLK), .local_rst(local_rst),
		.cmd_we(cmd_we), .cmd_data(cmd_data), .cmd_credit(cmd_credit),
		.rbk_valid(rbk_valid), .rbk_data(rbk_data), .rbk_credit(rbk_credit),
		.bpi_busy(bpi_busy), .bpi_data_from(bpi_data_from), .bpi_load_data(bpi_load_data),
		.bpi_execute(bpi_execute), .bpi_op(bpi_op), .bpi_addr(bpi_addr),
		.bpi_data_to(bpi_data_to), .bpi_status(bpi_status), .bpi_active(bpi_active)
	);

	always #2 CLK = ~CLK;

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	function automatic word_t cmd_word(input cmd_code_t code, input int arg);
		cmd_arg_t a;
		a = cmd_arg_t'(arg);
		return {a, code};
	endfunction

	function automatic int credits_avail();
		return CMD_DEPTH + cr_rx - wr_cnt;
	endfunction

	//////////////////////////////////////////////////
	// Host side tasks, called on a falling edge
	//////////////////////////////////////////////////

	task automatic send_word(input word_t w);
		int t;
		t = 0;
		while ((credits_avail() <= 0) && (t < 500))
		begin
			@(negedge CLK);
			t++;
		end
		if (t >= 500)
		begin
			other_cnt++;
			$display("Timeout waiting for a command credit at %0t", $time);
		end
		cmd_we   = 1'b1;
		cmd_data = w;
		wr_cnt++;
		@(negedge CLK);
		cmd_we = 1'b0;
	endtask

	task automatic load_address(input flash_addr_t a);
		send_word(cmd_word(CMD_LOAD_ADDRESS, a[22:16]));
		send_word(a[15:0]);
		cur_addr = a;
	endtask

	task automatic expect_bus(input bus_op_t op, input flash_addr_t a, input word_t d);
		exp_op.push_back(op);
		exp_addr.push_back(a);
		exp_dat.push_back(d);
	endtask

	task automatic expect_reads(input flash_addr_t a, input int n);
		flash_addr_t t;
		for (int i = 0; i < n; i++)
		begin
			t = a + flash_addr_t'(i);
			expect_bus(OP_READ, t, '0);
			exp_rbk.push_back(t[15:0] ^ 16'hA5C3);	// Array read rule
		end
	endtask

	task automatic wait_idle();
		int t;
		int quiet;
		t = 0;
		quiet = 0;
		while ((quiet < 8) && (t < 3000))
		begin
			@(negedge CLK);
			t++;
			if (!bpi_active && !bpi_busy && (exp_op.size() == 0))
				quiet++;
			else
				quiet = 0;
		end
		if (quiet < 8)
		begin
			other_cnt++;
			$display("Timeout waiting for the controller to go idle at %0t", $time);
		end
	endtask

	task automatic wait_rbk();
		int t;
		t = 0;
		while ((exp_rbk.size() != 0) && (t < 1000))
		begin
			@(negedge CLK);
			t++;
		end
		if (exp_rbk.size() != 0)
		begin
			other_cnt++;
			$display("Timeout waiting for %0d readback words", exp_rbk.size());
		end
	endtask

	task automatic run_erase(input flash_addr_t a);
		flash_addr_t blk;
		logic [6:0]  pat;
		int          n;
		pat       = 7'($urandom);
		n         = $urandom_range(0, 3);
		poll_plan = n;
		err_pat   = pat;
		send_word(cmd_word(CMD_CLR_BPI_STATUS, 0));
		load_address(a);
		blk = (a >= PARAM_START) ? (a & PARAM_BLOCK_MASK) : (a & MAIN_BLOCK_MASK);
		expect_bus(OP_WRITE, blk, 16'h0020);
		expect_bus(OP_WRITE, blk, 16'h00D0);
		for (int i = 0; i <= n; i++)
			expect_bus(OP_READ, a & BANK_MASK, '0);	// Polls until ready
		send_word(cmd_word(CMD_BLOCK_ERASE, 0));
		wait_idle();
		compare_value("bpi_status[7:0]", bpi_status[7:0], {1'b1, pat});
		compare_value("bpi_status[8]", bpi_status[8], |(pat & 7'h2A));
	endtask

	//////////////////////////////////////////////////
	// Bus log, credits and readback checks
	//////////////////////////////////////////////////

	always @(posedge CLK)
	begin
		if (!local_rst && bpi_execute)
		begin
			pend_op   = bpi_op;
			pend_addr = bpi_addr;
			pend_data = bpi_data_to;
			exec_tog  = !exec_tog;
			if (exp_op.size() == 0)
			begin
				other_cnt++;
				$display("Unexpected bus cycle at %0t, address %h", $time, bpi_addr);
			end
			else
			begin
				e_op = exp_op.pop_front();
				compare_value("bpi_op", bpi_op, e_op);
				compare_value("bpi_addr", bpi_addr, exp_addr.pop_front());
				if (e_op == OP_WRITE)
					compare_value("bpi_data_to", bpi_data_to, exp_dat.pop_front());
				else
					void'(exp_dat.pop_front());
			end
		end
		if (!local_rst && cmd_credit)
			cr_rx++;
		if (!local_rst && rbk_valid)
		begin
			// A credit returned in this cycle counts from the next one
			assert (rbk_rx < RBK_DEPTH + ret_cnt - int'(rbk_credit))
			else
			begin
				other_cnt++;
				$display("Readback word sent beyond the credits returned at %0t", $time);
			end
			rbk_rx++;
			if (exp_rbk.size() == 0)
			begin
				other_cnt++;
				$display("Unexpected readback word %h at %0t", rbk_data, $time);
			end
			else
				compare_value("rbk_data", rbk_data, exp_rbk.pop_front());
		end
	end

	// Host returns one credit per word taken
	always @(negedge CLK)
	begin
		rbk_credit = 1'b0;
		if (!withhold && (ret_cnt < rbk_rx))
		begin
			rbk_credit = 1'b1;
			ret_cnt++;
		end
	end

	//////////////////////////////////////////////////
	// Flash model
	//////////////////////////////////////////////////

	always @(negedge CLK)
	begin
		bpi_load_data = 1'b0;
		if (busy_cnt != 0)
		begin
			busy_cnt--;
			if (busy_cnt == 0)
				bpi_busy = 1'b0;
			else if ((busy_cnt == 1) && m_read)
			begin
				bpi_load_data = 1'b1;
				if (!st_mode)
					bpi_data_from = pend_addr[15:0] ^ 16'hA5C3;
				else if (polls_left > 0)
				begin
					bpi_data_from = 16'h0000;	// Still busy
					polls_left--;
				end
				else
					bpi_data_from = {8'h00, 1'b1, err_pat};
			end
		end
		else if (exec_tog != seen_tog)
		begin
			seen_tog = exec_tog;
			bpi_busy = 1'b1;
			busy_cnt = 1 + $urandom_range(1, 4);
			m_read   = (pend_op == OP_READ);
			if (!m_read && prog_next)
			begin
				prog_next  = 1'b0;	// Program data word
				st_mode    = 1'b1;
				polls_left = poll_plan;
			end
			else if (!m_read)
				case (pend_data)
					16'h00FF: st_mode = 1'b0;
					16'h0070:
					begin
						st_mode    = 1'b1;
						polls_left = 0;
					end
					16'h00D0:
					begin
						st_mode    = 1'b1;
						polls_left = poll_plan;
					end
					16'h0040: prog_next = 1'b1;
					default: ;
				endcase
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		flash_addr_t a;
		word_t       d;
		logic [6:0]  pat;
		logic [7:0]  sr_keep;
		int          n;
		int          t;
		void'($urandom(32'hdb10b7bd));
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		local_rst = 1'b0;
		@(negedge CLK);
		compare_value("bpi_execute", bpi_execute, 0);
		compare_value("cmd_credit", cmd_credit, 0);
		compare_value("rbk_valid", rbk_valid, 0);
		compare_value("bpi_active", bpi_active, 0);
		compare_value("bpi_status", bpi_status, 0);

		// Block reads
		expect_bus(OP_WRITE, cur_addr & BANK_MASK, 16'h00FF);
		send_word(cmd_word(CMD_READ_ARRAY, 0));
		a = {7'($urandom), 16'($urandom) & 16'h7FFF};
		load_address(a);
		expect_reads(a, 5);
		send_word(cmd_word(CMD_READ_N, 4));
		cur_addr = a + 23'd5;
		expect_reads(cur_addr, 1);
		send_word(cmd_word(CMD_READ_1, 0));
		cur_addr = cur_addr + 23'd1;
		wait_idle();
		wait_rbk();

		// Main block, then parameter block
		run_erase({7'($urandom_range(0, 126)), 16'($urandom)});
		run_erase({7'h7F, 16'($urandom)});

		// Program checked against error mask 0x1A
		pat       = 7'($urandom) | 7'h10;
		n         = $urandom_range(0, 3);
		poll_plan = n;
		err_pat   = pat;
		d         = 16'($urandom);
		send_word(cmd_word(CMD_CLR_BPI_STATUS, 0));
		expect_bus(OP_WRITE, cur_addr, 16'h0040);
		expect_bus(OP_WRITE, cur_addr, d);
		for (int i = 0; i <= n; i++)
			expect_bus(OP_READ, cur_addr & BANK_MASK, '0);
		send_word(cmd_word(CMD_PROGRAM, 0));
		send_word(d);
		cur_addr = cur_addr + 23'd1;
		wait_idle();
		compare_value("bpi_status[7:0]", bpi_status[7:0], {1'b1, pat});
		compare_value("bpi_status[8]", bpi_status[8], |(pat & 7'h1A));
		sr_keep = bpi_status[7:0];
		send_word(cmd_word(CMD_CLR_BPI_STATUS, 0));
		wait_idle();
		compare_value("bpi_status[9:8]", bpi_status[9:8], 0);
		compare_value("bpi_status[7:0]", bpi_status[7:0], sr_keep);

		// Status register read and clear
		err_pat = 7'($urandom);
		expect_bus(OP_WRITE, cur_addr & BANK_MASK, 16'h0070);
		expect_bus(OP_READ, cur_addr & BANK_MASK, '0);
		send_word(cmd_word(CMD_READ_STATUS, 0));
		wait_idle();
		compare_value("bpi_status[7:0]", bpi_status[7:0], {1'b1, err_pat});
		expect_bus(OP_WRITE, cur_addr & BANK_MASK, 16'h0050);
		send_word(cmd_word(CMD_CLR_STATUS_REG, 0));
		wait_idle();

		// Flow control with readback credits held back
		expect_bus(OP_WRITE, cur_addr & BANK_MASK, 16'h00FF);
		send_word(cmd_word(CMD_READ_ARRAY, 0));
		a = {7'($urandom), 16'($urandom) & 16'h7FFF};
		load_address(a);
		withhold = 1'b1;
		expect_reads(a, 12);
		send_word(cmd_word(CMD_READ_N, 11));
		cur_addr = a + 23'd12;
		t = 0;
		while ((credits_avail() > 0) && (t < 40))
		begin
			send_word(cmd_word(CMD_NOOP, 0));	// Parser stalls and the FIFO fills
			t++;
		end
		cmd_we   = 1'b1;	// Write with no credit into the full FIFO
		cmd_data = cmd_word(CMD_NOOP, 0);
		@(negedge CLK);
		cmd_we = 1'b0;
		wait_idle();
		compare_value("bpi_status[9]", bpi_status[9], 1);
		withhold = 1'b0;
		wait_rbk();
		wait_idle();
		compare_value("cmd_credit pulses", cr_rx, wr_cnt);
		compare_value("readback words", rbk_rx, 18);
		compare_value("bus cycles left", exp_op.size(), 0);

		$display("Checks done: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatch_cnt, other_cnt, u_bpi_ctrl_top.u_bpi_ctrl_sva.sva_errs);
		if ((mismatch_cnt == 0) && (other_cnt == 0)
			&& (u_bpi_ctrl_top.u_bpi_ctrl_sva.sva_errs == 0))
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* bench/bpi_ctrl_sva.sv */
`timescale 1ns/100ps

module bpi_ctrl_sva (
	input logic        CLK,
	input logic        local_rst,
	input logic        bpi_execute,
	input logic        bpi_busy,
	input logic        bpi_active,
	input logic        cmd_credit,
	input logic        rbk_valid,
	input logic        rbk_credit,
	input logic [15:0] bpi_status
);

	import bpi_flash_pkg::*;

	int   sva_errs = 0;	// Assertion failures
	int   host_credits;	// Readback credits as the host sees them
	logic cyc_open;		// Bus cycle issued and not yet ended
	logic busy_seen;

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			host_credits <= RBK_DEPTH;
			cyc_open     <= 1'b0;
			busy_seen    <= 1'b0;
		end
		else
		begin
			host_credits <= host_credits + int'(rbk_credit) - int'(rbk_valid);
			if (bpi_execute)
			begin
				cyc_open  <= 1'b1;
				busy_seen <= 1'b0;
			end
			else if (bpi_busy)
				busy_seen <= 1'b1;
			else if (busy_seen)
				cyc_open <= 1'b0;	// Busy went high and low again
		end
	end

	//////////////////////////////////////////////////
	// Flash bus handshake
	//////////////////////////////////////////////////

	a_exec_not_busy: assert property (@(posedge CLK) disable iff (local_rst)
		bpi_execute |-> (!bpi_busy && !cyc_open))
		else
		begin
			sva_errs++;
			$error("bpi_execute fired while a bus cycle was still open");
		end

	// Interface answers within two cycles
	a_busy_rises: assert property (@(posedge CLK) disable iff (local_rst)
		bpi_execute |=> ##[0:1] bpi_busy)
		else
		begin
			sva_errs++;
			$error("bpi_busy did not rise after bpi_execute");
		end

	//////////////////////////////////////////////////
	// Readback credits and reset values
	//////////////////////////////////////////////////

	a_valid_needs_credit: assert property (@(posedge CLK) disable iff (local_rst)
		rbk_valid |-> (host_credits > 0))
		else
		begin
			sva_errs++;
			$error("rbk_valid fired with no readback credit");
		end

	// Quiet outputs right after reset
	a_reset_quiet: assert property (@(posedge CLK)
		$fell(local_rst) |-> (!bpi_execute && !cmd_credit && !rbk_valid && !bpi_active
			&& (bpi_status == '0)))
		else
		begin
			sva_errs++;
			$error("Outputs not quiet after reset");
		end

endmodule

bind bpi_ctrl_top bpi_ctrl_sva u_bpi_ctrl_sva (
	.CLK(CLK), .local_rst(local_rst),
	.bpi_execute(bpi_execute), .bpi_busy(bpi_busy), .bpi_active(bpi_active),
	.cmd_credit(cmd_credit), .rbk_valid(rbk_valid), .rbk_credit(rbk_credit),
	.bpi_status(bpi_status)
);

/* verilog/bpi_ctrl_top.sv */
`timescale 1ns/100ps

module bpi_ctrl_top (
	input  logic                       CLK,
	input  logic                       local_rst,
	// Host command port
	input  logic                       cmd_we,
	input  bpi_flash_pkg::word_t       cmd_data,
	output logic                       cmd_credit,
	// Host readback port
	output logic                       rbk_valid,
	output bpi_flash_pkg::word_t       rbk_data,
	input  logic                       rbk_credit,
	// Low level flash bus
	input  logic                       bpi_busy,
	input  bpi_flash_pkg::word_t       bpi_data_from,
	input  logic                       bpi_load_data,
	output logic                       bpi_execute,
	output bpi_cmd_pkg::bus_op_t       bpi_op,
	output bpi_flash_pkg::flash_addr_t bpi_addr,
	output bpi_flash_pkg::word_t       bpi_data_to,
	output bpi_flash_pkg::word_t       bpi_status,
	output logic                       bpi_active
);

	import bpi_cmd_pkg::*;
	import bpi_flash_pkg::*;

	word_t       fifo_data;
	logic        fifo_empty;
	logic        fifo_pop;
	logic        cmd_overflow;
	logic        op_valid;
	cmd_code_t   op_cmd;
	flash_addr_t op_addr;
	word_t       op_data;
	cmd_arg_t    op_count;
	logic        op_done;
	logic        addr_step;
	logic        clr_status;
	logic        rbk_push;
	word_t       rbk_wdata;
	logic        rbk_full;

	bpi_cmd_fifo u_bpi_cmd_fifo (
		.CLK(CLK), .local_rst(local_rst),
		.cmd_we(cmd_we), .cmd_data(cmd_data), .fifo_pop(fifo_pop),
		.fifo_data(fifo_data), .fifo_empty(fifo_empty),
		.cmd_credit(cmd_credit), .cmd_overflow(cmd_overflow)
	);

	bpi_cmd_parser u_bpi_cmd_parser (
		.CLK(CLK), .local_rst(local_rst),
		.fifo_data(fifo_data), .fifo_empty(fifo_empty),
		.op_done(op_done), .addr_step(addr_step), .fifo_pop(fifo_pop),
		.op_valid(op_valid), .op_cmd(op_cmd), .op_addr(op_addr),
		.op_data(op_data), .op_count(op_count),
		.clr_status(clr_status), .bpi_active(bpi_active)
	);

	bpi_cycle_gen u_bpi_cycle_gen (
		.CLK(CLK), .local_rst(local_rst),
		.op_valid(op_valid), .op_cmd(op_cmd), .op_addr(op_addr),
		.op_data(op_data), .op_count(op_count),
		.clr_status(clr_status), .cmd_overflow(cmd_overflow),
		.bpi_busy(bpi_busy), .bpi_load_data(bpi_load_data),
		.bpi_data_from(bpi_data_from), .rbk_full(rbk_full),
		.op_done(op_done), .addr_step(addr_step), .bpi_execute(bpi_execute),
		.bpi_op(bpi_op), .bpi_addr(bpi_addr), .bpi_data_to(bpi_data_to),
		.rbk_push(rbk_push), .rbk_wdata(rbk_wdata), .bpi_status(bpi_status)
	);

	bpi_rbk_out u_bpi_rbk_out (
		.CLK(CLK), .local_rst(local_rst),
		.rbk_push(rbk_push), .rbk_wdata(rbk_wdata), .rbk_credit(rbk_credit),
		.rbk_full(rbk_full), .rbk_valid(rbk_valid), .rbk_data(rbk_data)
	);

endmodule

/* verilog/bpi_rbk_out.sv */
`timescale 1ns/100ps

module bpi_rbk_out (
	input  logic                 CLK,
	input  logic                 local_rst,
	input  logic                 rbk_push,
	input  bpi_flash_pkg::word_t rbk_wdata,
	input  logic                 rbk_credit,
	output logic                 rbk_full,
	output logic                 rbk_valid,
	output bpi_flash_pkg::word_t rbk_data
);

	import bpi_flash_pkg::*;

	word_t    mem [RBK_DEPTH];
	rbk_ptr_t wr_ptr;
	rbk_ptr_t rd_ptr;
	rbk_cnt_t count;
	rbk_cnt_t credits;	// Words the host can still take
	logic     push_ok;
	logic     send;

	assign rbk_full  = (count == rbk_cnt_t'(RBK_DEPTH));
	assign push_ok   = rbk_push && !rbk_full;
	assign send      = (count != '0) && (credits != '0);
	assign rbk_valid = send;
	assign rbk_data  = mem[rd_ptr];

	always_ff @(posedge CLK)
	begin
		if (push_ok)
			mem[wr_ptr] <= rbk_wdata;
	end

	//////////////////////////////////////////////////
	// Pointers, fill level and host credits
	//////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= rbk_cnt_t'(RBK_DEPTH);	// Host starts with a full buffer
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, send})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({rbk_credit, send})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

/* verilog/bpi_cycle_gen.sv */
`timescale 1ns/100ps

module bpi_cycle_gen (
	input  logic                       CLK,
	input  logic                       local_rst,
	input  logic                       op_valid,
	input  bpi_cmd_pkg::cmd_code_t     op_cmd,
	input  bpi_flash_pkg::flash_addr_t op_addr,
	input  bpi_flash_pkg::word_t       op_data,
	input  bpi_cmd_pkg::cmd_arg_t      op_count,
	input  logic                       clr_status,
	input  logic                       cmd_overflow,
	input  logic                       bpi_busy,
	input  logic                       bpi_load_data,
	input  bpi_flash_pkg::word_t       bpi_data_from,
	input  logic                       rbk_full,
	output logic                       op_done,
	output logic                       addr_step,
	output logic                       bpi_execute,
	output bpi_cmd_pkg::bus_op_t       bpi_op,
	output bpi_flash_pkg::flash_addr_t bpi_addr,
	output bpi_flash_pkg::word_t       bpi_data_to,
	output logic                       rbk_push,
	output bpi_flash_pkg::word_t       rbk_wdata,
	output bpi_flash_pkg::word_t       bpi_status
);

	import bpi_cmd_pkg::*;
	import bpi_flash_pkg::*;

	typedef enum logic [2:0] {
		G_IDLE,
		G_ISSUE,	// Wait for a free bus, then execute
		G_WAIT_HI,	// Wait for busy to rise
		G_WAIT_LO,	// Wait for the end of the cycle
		G_DONE
	} gen_state_t;

	gen_state_t  state;
	logic [1:0]  cyc;	// 0 and 1 command cycles, 2 status poll
	cmd_arg_t    rd_idx;
	sr_t         sr_reg;
	logic        pe_err;
	logic        ovf_err;
	flash_addr_t bank_addr;
	flash_addr_t block_addr;
	logic        rd_array;	// Read that goes to the readback FIFO
	logic        rd_sr;	// Read that captures the status register
	logic        in_cycle;
	logic        cyc_end;
	logic        ready;
	logic        op_failed;

	assign bank_addr  = op_addr & BANK_MASK;
	assign block_addr = (op_addr >= PARAM_START) ? (op_addr & PARAM_BLOCK_MASK)
	                                             : (op_addr & MAIN_BLOCK_MASK);

	//////////////////////////////////////////////////
	// Bus cycle for the current command and step
	//////////////////////////////////////////////////

	always_comb
	begin
		bpi_op      = OP_WRITE;
		bpi_addr    = bank_addr;
		bpi_data_to = '0;
		rd_array    = 1'b0;
		rd_sr       = 1'b0;
		case (op_cmd)
			CMD_READ_ARRAY:
				bpi_data_to = OPC_READ_ARRAY;
			CMD_CLR_STATUS_REG:
				bpi_data_to = OPC_CLR_SR;
			CMD_READ_STATUS:
				if (cyc == 2'd0)
					bpi_data_to = OPC_READ_SR;
				else
				begin
					bpi_op = OP_READ;
					rd_sr  = 1'b1;
				end
			CMD_BLOCK_ERASE, CMD_PROGRAM:
				if (cyc == 2'd2)
				begin
					bpi_op = OP_READ;	// Status poll at the bank
					rd_sr  = 1'b1;
				end
				else if (op_cmd == CMD_BLOCK_ERASE)
				begin
					bpi_addr    = block_addr;
					bpi_data_to = (cyc == 2'd0) ? OPC_ERASE : OPC_CONFIRM;
				end
				else
				begin
					bpi_addr    = op_addr;
					bpi_data_to = (cyc == 2'd0) ? OPC_PROGRAM : op_data;
				end
			CMD_READ_1, CMD_READ_N:
			begin
				bpi_op   = OP_READ;
				bpi_addr = op_addr + flash_addr_t'(rd_idx);
				rd_array = 1'b1;
			end
			default: ;
		endcase
	end

	assign bpi_execute = (state == G_ISSUE) && !bpi_busy && !(rd_array && rbk_full);
	assign in_cycle    = (state == G_WAIT_HI) || (state == G_WAIT_LO);
	assign cyc_end     = (state == G_WAIT_LO) && !bpi_busy;
	assign rbk_push    = in_cycle && bpi_load_data && rd_array;
	assign rbk_wdata   = bpi_data_from;
	assign addr_step   = cyc_end && (rd_array || ((op_cmd == CMD_PROGRAM) && (cyc == 2'd1)));
	assign op_done     = (state == G_DONE);
	assign ready       = sr_reg[SR_READY_BIT];
	assign op_failed   = (op_cmd == CMD_BLOCK_ERASE) ? |(sr_reg & ERASE_ERR_MASK)
	                                                 : |(sr_reg & PROG_ERR_MASK);
	assign bpi_status  = {6'b000000, ovf_err, pe_err, sr_reg};

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state   <= G_IDLE;
			cyc     <= 2'd0;
			rd_idx  <= '0;
			sr_reg  <= '0;
			pe_err  <= 1'b0;
			ovf_err <= 1'b0;
		end
		else
		begin
			if (in_cycle && bpi_load_data && rd_sr)
				sr_reg <= bpi_data_from[7:0];
			ovf_err <= cmd_overflow || (ovf_err && !clr_status);
			if (clr_status)
				pe_err <= 1'b0;
			case (state)
				G_IDLE:
					if (op_valid)
					begin
						cyc    <= 2'd0;
						rd_idx <= '0;
						state  <= G_ISSUE;
					end
				G_ISSUE:
					if (bpi_execute)
						state <= G_WAIT_HI;
				G_WAIT_HI:
					if (bpi_busy)
						state <= G_WAIT_LO;
				G_WAIT_LO:
					if (cyc_end)
					begin
						state <= G_DONE;
						case (op_cmd)
							CMD_READ_N:
								if (rd_idx != op_count)
								begin
									rd_idx <= rd_idx + 1'b1;
									state  <= G_ISSUE;
								end
							CMD_READ_STATUS:
								if (cyc == 2'd0)
								begin
									cyc   <= 2'd1;
									state <= G_ISSUE;
								end
							CMD_BLOCK_ERASE, CMD_PROGRAM:
								if (cyc != 2'd2)
								begin
									cyc   <= cyc + 1'b1;
									state <= G_ISSUE;
								end
								else if (!ready)
									state <= G_ISSUE;	// Poll again
								else if (op_failed)
									pe_err <= 1'b1;
							default: ;
						endcase
					end
				G_DONE:
					state <= G_IDLE;
				default:
					state <= G_IDLE;
			endcase
		end
	end

endmodule

/* verilog/bpi_cmd_parser.sv */
`timescale 1ns/100ps

module bpi_cmd_parser (
	input  logic                      CLK,
	input  logic                      local_rst,
	input  bpi_flash_pkg::word_t      fifo_data,
	input  logic                      fifo_empty,
	input  logic                      op_done,
	input  logic                      addr_step,
	output logic                      fifo_pop,
	output logic                      op_valid,
	output bpi_cmd_pkg::cmd_code_t    op_cmd,
	output bpi_flash_pkg::flash_addr_t op_addr,
	output bpi_flash_pkg::word_t      op_data,
	output bpi_cmd_pkg::cmd_arg_t     op_count,
	output logic                      clr_status,
	output logic                      bpi_active
);

	import bpi_cmd_pkg::*;
	import bpi_flash_pkg::*;

	typedef enum logic [1:0] {
		P_IDLE,
		P_DECODE,	// Command word held, waits for a free slot
		P_EXTRA		// Waits for the offset or program data
	} parse_state_t;

	parse_state_t state;
	cmd_code_t    cmd_reg;
	cmd_arg_t     arg_reg;
	base_addr_t   base_addr;
	word_t        offset;
	logic         pass_cmd;
	logic         decode_go;
	logic         extra_go;
	logic         issue;

	// Commands that go straight to the cycle generator
	always_comb
	begin
		case (cmd_reg)
			CMD_READ_1, CMD_READ_N, CMD_READ_ARRAY, CMD_READ_STATUS,
			CMD_CLR_STATUS_REG, CMD_BLOCK_ERASE:
				pass_cmd = 1'b1;
			default:
				pass_cmd = 1'b0;
		endcase
	end

	assign decode_go  = (state == P_DECODE) && !op_valid;	// Keep command order
	assign extra_go   = (state == P_EXTRA) && !fifo_empty;
	assign issue      = (decode_go && pass_cmd) || (extra_go && (cmd_reg == CMD_PROGRAM));
	assign fifo_pop   = ((state == P_IDLE) || (state == P_EXTRA)) && !fifo_empty;
	assign bpi_active = (state != P_IDLE) || op_valid;

	always_ff @(posedge CLK)
	begin
		if ((state == P_IDLE) && !fifo_empty)
		begin
			cmd_reg <= cmd_code_t'(fifo_data[CMD_W-1:0]);
			arg_reg <= fifo_data[CMD_W+ARG_W-1:CMD_W];
		end
		if (issue)
		begin
			op_cmd   <= cmd_reg;
			op_addr  <= {base_addr, offset};
			op_data  <= fifo_data;	// Only meaningful for Program
			op_count <= arg_reg;
		end
	end

	//////////////////////////////////////////////////
	// State machine and address pointer
	//////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state      <= P_IDLE;
			op_valid   <= 1'b0;
			clr_status <= 1'b0;
			base_addr  <= '0;
			offset     <= '0;
		end
		else
		begin
			clr_status <= decode_go && (cmd_reg == CMD_CLR_BPI_STATUS);
			if (op_done)
				op_valid <= 1'b0;
			else if (issue)
				op_valid <= 1'b1;
			if (extra_go && (cmd_reg == CMD_LOAD_ADDRESS))
			begin
				base_addr <= arg_reg[6:0];
				offset    <= fifo_data;
			end
			else if (addr_step)
				offset <= offset + 1'b1;
			case (state)
				P_IDLE:
					if (!fifo_empty)
						state <= P_DECODE;
				P_DECODE:
					if (decode_go)
					begin
						if ((cmd_reg == CMD_LOAD_ADDRESS) || (cmd_reg == CMD_PROGRAM))
							state <= P_EXTRA;
						else
							state <= P_IDLE;	// NoOp and unknown codes dropped here
					end
				P_EXTRA:
					if (extra_go)
						state <= P_IDLE;
				default:
					state <= P_IDLE;
			endcase
		end
	end

endmodule

/* verilog/bpi_cmd_fifo.sv */
`timescale 1ns/100ps

module bpi_cmd_fifo (
	input  logic                 CLK,
	input  logic                 local_rst,
	input  logic                 cmd_we,
	input  bpi_flash_pkg::word_t cmd_data,
	input  logic                 fifo_pop,
	output bpi_flash_pkg::word_t fifo_data,
	output logic                 fifo_empty,
	output logic                 cmd_credit,
	output logic                 cmd_overflow
);

	import bpi_flash_pkg::*;

	word_t    mem [CMD_DEPTH];
	cmd_ptr_t wr_ptr;
	cmd_ptr_t rd_ptr;
	cmd_cnt_t count;
	logic     full;
	logic     wr_ok;
	logic     rd_ok;

	assign full       = (count == cmd_cnt_t'(CMD_DEPTH));
	assign fifo_empty = (count == '0);
	assign fifo_data  = mem[rd_ptr];	// Head word falls through
	assign wr_ok      = cmd_we && !full;
	assign rd_ok      = fifo_pop && !fifo_empty;

	always_ff @(posedge CLK)
	begin
		if (wr_ok)
			mem[wr_ptr] <= cmd_data;
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			cmd_credit   <= 1'b0;
			cmd_overflow <= 1'b0;
		end
		else
		begin
			cmd_credit   <= rd_ok;		// One credit back per word taken
			cmd_overflow <= cmd_we && full;	// Write lost
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* verilog/bpi_flash_pkg.sv */
package bpi_flash_pkg;

	typedef logic [15:0] word_t;
	typedef logic [22:0] flash_addr_t;	// Word address
	typedef logic [6:0]  base_addr_t;	// Upper address bits from Load_Address
	typedef logic [7:0]  sr_t;		// PROM status register

	// Bank and block masks
	localparam flash_addr_t BANK_MASK        = 23'h780000;
	localparam flash_addr_t PARAM_START      = 23'h7F0000;	// 16 KWord blocks from here up
	localparam flash_addr_t PARAM_BLOCK_MASK = 23'h7FC000;
	localparam flash_addr_t MAIN_BLOCK_MASK  = 23'h7F0000;

	// Status register
	localparam int  SR_READY_BIT   = 7;
	localparam sr_t ERASE_ERR_MASK = 8'h2A;
	localparam sr_t PROG_ERR_MASK  = 8'h1A;

	// FIFO sizes
	localparam int CMD_DEPTH = 16;
	localparam int RBK_DEPTH = 8;

	typedef logic [$clog2(CMD_DEPTH)-1:0] cmd_ptr_t;
	typedef logic [$clog2(CMD_DEPTH):0]   cmd_cnt_t;
	typedef logic [$clog2(RBK_DEPTH)-1:0] rbk_ptr_t;
	typedef logic [$clog2(RBK_DEPTH):0]   rbk_cnt_t;

endpackage

/* verilog/bpi_cmd_pkg.sv */
package bpi_cmd_pkg;

	//////////////////////////////////////////////////
	// Command word layout
	//////////////////////////////////////////////////

	localparam int CMD_W = 5;	// Code in bits 4:0
	localparam int ARG_W = 11;	// Argument in bits 15:5

	// Host command codes
	typedef enum logic [CMD_W-1:0] {
		CMD_NOOP           = 5'h00,
		CMD_READ_1         = 5'h02,
		CMD_READ_N         = 5'h04,
		CMD_READ_ARRAY     = 5'h05,
		CMD_READ_STATUS    = 5'h06,
		CMD_CLR_STATUS_REG = 5'h09,
		CMD_BLOCK_ERASE    = 5'h0A,
		CMD_PROGRAM        = 5'h0B,
		CMD_LOAD_ADDRESS   = 5'h17,	// Local, consumed by the parser
		CMD_CLR_BPI_STATUS = 5'h1C	// Local, clears sticky bits
	} cmd_code_t;

	// n-1 for Read_n, base address for Load_Address
	typedef logic [ARG_W-1:0] cmd_arg_t;

	//////////////////////////////////////////////////
	// Flash opcodes
	//////////////////////////////////////////////////

	typedef logic [15:0] opcode_t;

	localparam opcode_t OPC_READ_ARRAY = 16'h00FF;
	localparam opcode_t OPC_READ_SR    = 16'h0070;
	localparam opcode_t OPC_CLR_SR     = 16'h0050;
	localparam opcode_t OPC_ERASE      = 16'h0020;
	localparam opcode_t OPC_CONFIRM    = 16'h00D0;	// Second cycle of erase
	localparam opcode_t OPC_PROGRAM    = 16'h0040;

	// Bus operation toward the low level interface
	typedef logic [1:0] bus_op_t;

	localparam bus_op_t OP_READ  = 2'b10;
	localparam bus_op_t OP_WRITE = 2'b01;

endpackage
